//--- mock_cce_pkg.sv
// sizes, coherence enums and message structs for the mock CCE
`default_nettype none

package mock_cce_pkg;

  // block address splits into tag and set index
  localparam int block_addr_width_lp = 8;
  localparam int num_sets_lp         = 16;
  localparam int set_idx_width_lp    = 4;
  localparam int tag_width_lp        = block_addr_width_lp - set_idx_width_lp;

  localparam int lce_assoc_lp  = 2;
  localparam int way_width_lp  = 1;

  localparam int block_width_lp = 32;
  localparam int num_blocks_lp  = 1 << block_addr_width_lp;

  typedef enum logic [1:0] {
    e_coh_invalid  = 2'b00,
    e_coh_shared   = 2'b01,
    e_coh_modified = 2'b10
  } coh_state_e;

  typedef enum logic [1:0] {
    e_cmd_writeback      = 2'b00,
    e_cmd_set_tag        = 2'b01,
    e_cmd_set_tag_wakeup = 2'b10
  } cmd_type_e;

  typedef enum logic [1:0] {
    e_req_normal    = 2'b00,
    e_req_normal_wb = 2'b01,
    e_req_upgrade   = 2'b10
  } req_class_e;

  // miss request from the LCE
  typedef struct packed {
    logic [block_addr_width_lp-1:0] addr;
    logic                           wr;
    logic [way_width_lp-1:0]        lru_way;
    logic                           lru_dirty;
  } lce_req_s;

  // set-tag acknowledge
  typedef struct packed {
    logic [block_addr_width_lp-1:0] addr;
  } lce_resp_s;

  typedef struct packed {
    logic [block_addr_width_lp-1:0] addr;
    logic [block_width_lp-1:0]      data;
  } lce_data_resp_s;

  typedef struct packed {
    cmd_type_e                      cmd_type;
    logic [block_addr_width_lp-1:0] addr;
    logic [way_width_lp-1:0]        way;
    coh_state_e                     state;
  } cce_cmd_s;

  typedef struct packed {
    logic [block_addr_width_lp-1:0] addr;
    logic [way_width_lp-1:0]        way;
    coh_state_e                     state;
    logic [block_width_lp-1:0]      data;
  } cce_data_cmd_s;

  typedef struct packed {
    logic [tag_width_lp-1:0] tag;
    coh_state_e              state;
  } dir_entry_s;

  // work handed from directory lookup to command issue
  typedef struct packed {
    req_class_e                     req_class;
    logic [block_addr_width_lp-1:0] addr;
    logic [way_width_lp-1:0]        way;
    coh_state_e                     state;
    logic [block_addr_width_lp-1:0] wb_addr;
  } cce_job_s;

endpackage

`default_nettype wire

//--- two_entry_fifo.sv
// two-entry ready/valid queue with a typed payload
`timescale 1ns/1ps
`default_nettype none

module two_entry_fifo #(
  parameter type payload_t = logic
) (
  input  wire logic     clk_i,
  input  wire logic     reset_i,

  // enqueue side, ready then valid
  input  wire logic     v_i,
  input  wire payload_t data_i,
  output logic          ready_o,

  // dequeue side, valid then yumi
  output logic          v_o,
  output payload_t      data_o,
  input  wire logic     yumi_i
);

  payload_t   mem_r [2];
  logic       wr_ptr_r;
  logic       rd_ptr_r;
  logic [1:0] count_r;
  logic       enq;
  logic       deq;

  assign ready_o = (count_r != 2'd2);
  assign v_o     = (count_r != 2'd0);
  assign data_o  = mem_r[rd_ptr_r];

  assign enq = v_i & ready_o;
  assign deq = yumi_i;

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      wr_ptr_r <= 1'b0;
      rd_ptr_r <= 1'b0;
      count_r  <= 2'd0;
    end else begin
      if (enq) begin
        wr_ptr_r <= ~wr_ptr_r;
      end
      if (deq) begin
        rd_ptr_r <= ~rd_ptr_r;
      end
      // simultaneous enq and deq leave the count alone
      count_r <= count_r + {1'b0, enq} - {1'b0, deq};
    end
  end

  always_ff @(posedge clk_i) begin
    if (enq) begin
      mem_r[wr_ptr_r] <= data_i;
    end
  end

endmodule

`default_nettype wire

//--- cce_dir_lookup.sv
// directory stage: request classification, tag/state update, job register
`timescale 1ns/1ps
`default_nettype none

module cce_dir_lookup (
  input  wire logic                     clk_i,
  input  wire logic                     reset_i,

  input  wire logic                     req_v_i,
  input  wire mock_cce_pkg::lce_req_s   req_i,
  output logic                          req_yumi_o,

  output logic                          job_v_o,
  output mock_cce_pkg::cce_job_s        job_o,
  input  wire logic                     job_ready_i
);

  mock_cce_pkg::dir_entry_s dir_r [mock_cce_pkg::num_sets_lp][mock_cce_pkg::lce_assoc_lp];

  logic                                      job_v_r;
  mock_cce_pkg::cce_job_s                    job_r;
  mock_cce_pkg::cce_job_s                    job_next;
  logic                                      load;
  logic [mock_cce_pkg::set_idx_width_lp-1:0] req_set;
  logic [mock_cce_pkg::tag_width_lp-1:0]     req_tag;
  logic [mock_cce_pkg::lce_assoc_lp-1:0]     shared_hit;
  logic [mock_cce_pkg::way_width_lp-1:0]     hit_way;
  logic                                      upgrade;

  assign req_set = req_i.addr[mock_cce_pkg::set_idx_width_lp-1:0];
  assign req_tag = req_i.addr[mock_cce_pkg::block_addr_width_lp-1 -: mock_cce_pkg::tag_width_lp];

  // look for the block already held shared in this set
  always_comb begin
    shared_hit = '0;
    hit_way    = '0;
    for (int w = 0; w < mock_cce_pkg::lce_assoc_lp; w++) begin
      shared_hit[w] = (dir_r[req_set][w].state == mock_cce_pkg::e_coh_shared)
                      && (dir_r[req_set][w].tag == req_tag);
      if (shared_hit[w]) begin
        hit_way = mock_cce_pkg::way_width_lp'(w);
      end
    end
  end

  assign upgrade = req_i.wr & (|shared_hit);

  always_comb begin
    job_next.req_class = upgrade ? mock_cce_pkg::e_req_upgrade
                       : req_i.lru_dirty ? mock_cce_pkg::e_req_normal_wb
                       : mock_cce_pkg::e_req_normal;
    job_next.addr      = req_i.addr;
    job_next.way       = upgrade ? hit_way : req_i.lru_way;
    job_next.state     = req_i.wr ? mock_cce_pkg::e_coh_modified : mock_cce_pkg::e_coh_shared;
    // evicted block lives in the LRU way of the same set
    job_next.wb_addr   = {dir_r[req_set][req_i.lru_way].tag, req_set};
  end

  // job register frees up on the same cycle it hands off
  assign load       = req_v_i & (~job_v_r | job_ready_i);
  assign req_yumi_o = load;
  assign job_v_o    = job_v_r;
  assign job_o      = job_r;

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      job_v_r <= 1'b0;
      for (int s = 0; s < mock_cce_pkg::num_sets_lp; s++) begin
        for (int w = 0; w < mock_cce_pkg::lce_assoc_lp; w++) begin
          dir_r[s][w] <= '{tag: '0, state: mock_cce_pkg::e_coh_invalid};
        end
      end
    end else begin
      if (load) begin
        job_v_r <= 1'b1;
        dir_r[req_set][job_next.way] <= '{tag: req_tag, state: job_next.state};
      end else if (job_ready_i) begin
        job_v_r <= 1'b0;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (load) begin
      job_r <= job_next;
    end
  end

endmodule

`default_nettype wire

//--- cce_block_mem.sv
// mock backing store of data blocks with registered read
`timescale 1ns/1ps
`default_nettype none

module cce_block_mem (
  input  wire logic                                        clk_i,
  input  wire logic                                        reset_i,

  input  wire logic [mock_cce_pkg::block_addr_width_lp-1:0] rd_addr_i,
  output logic [mock_cce_pkg::block_width_lp-1:0]          rd_data_o,

  input  wire logic                                        wr_v_i,
  input  wire logic [mock_cce_pkg::block_addr_width_lp-1:0] wr_addr_i,
  input  wire logic [mock_cce_pkg::block_width_lp-1:0]     wr_data_i
);

  logic [mock_cce_pkg::block_width_lp-1:0] mem_r [mock_cce_pkg::num_blocks_lp];
  logic [mock_cce_pkg::block_width_lp-1:0] rd_data_r;
  logic                                    fwd;

  // memory starts out all zero
  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      for (int i = 0; i < mock_cce_pkg::num_blocks_lp; i++) begin
        mem_r[i] <= '0;
      end
    end else if (wr_v_i) begin
      mem_r[wr_addr_i] <= wr_data_i;
    end
  end

  // write-first on an address collision
  assign fwd = wr_v_i & (wr_addr_i == rd_addr_i);

  always_ff @(posedge clk_i) begin
    rd_data_r <= fwd ? wr_data_i : mem_r[rd_addr_i];
  end

  assign rd_data_o = rd_data_r;

endmodule

`default_nettype wire

//--- cce_cmd_issue.sv
// command stage FSM: writeback, fill, set-tag and wakeup sequencing
`timescale 1ns/1ps
`default_nettype none

module cce_cmd_issue (
  input  wire logic                                        clk_i,
  input  wire logic                                        reset_i,

  input  wire logic                                        job_v_i,
  input  wire mock_cce_pkg::cce_job_s                      job_i,
  output logic                                             job_ready_o,

  input  wire logic                                        resp_v_i,
  input  wire mock_cce_pkg::lce_resp_s                     resp_i,
  output logic                                             resp_yumi_o,

  input  wire logic                                        data_resp_v_i,
  input  wire mock_cce_pkg::lce_data_resp_s                data_resp_i,
  output logic                                             data_resp_yumi_o,

  output logic                                             cmd_v_o,
  output mock_cce_pkg::cce_cmd_s                           cmd_o,
  input  wire logic                                        cmd_ready_i,

  output logic                                             data_cmd_v_o,
  output mock_cce_pkg::cce_data_cmd_s                      data_cmd_o,
  input  wire logic                                        data_cmd_ready_i,

  output logic [mock_cce_pkg::block_addr_width_lp-1:0]     mem_rd_addr_o,
  input  wire logic [mock_cce_pkg::block_width_lp-1:0]     mem_rd_data_i,
  output logic                                             mem_wr_v_o,
  output logic [mock_cce_pkg::block_addr_width_lp-1:0]     mem_wr_addr_o,
  output logic [mock_cce_pkg::block_width_lp-1:0]          mem_wr_data_o
);

  typedef enum logic [2:0] {
    e_idle, e_send_wb, e_wait_wb_data, e_read_mem,
    e_send_data, e_send_tag, e_wait_ack, e_send_wakeup
  } state_e;

  state_e                 state_r;
  mock_cce_pkg::cce_job_s job_r;
  logic                   ack_ok;

  assign job_ready_o = (state_r == e_idle);

  // ack must name the block just tagged
  assign ack_ok      = resp_v_i & (resp_i.addr == job_r.addr);
  assign resp_yumi_o = (state_r == e_wait_ack) & ack_ok;

  // writeback data goes straight into memory
  assign data_resp_yumi_o = (state_r == e_wait_wb_data) & data_resp_v_i;
  assign mem_wr_v_o       = data_resp_yumi_o;
  assign mem_wr_addr_o    = job_r.wb_addr;
  assign mem_wr_data_o    = data_resp_i.data;

  // read address stays put so the fill data is stable while stalled
  assign mem_rd_addr_o = job_r.addr;

  assign cmd_v_o = (state_r == e_send_wb) | (state_r == e_send_tag)
                 | (state_r == e_send_wakeup);
  assign cmd_o.cmd_type = (state_r == e_send_wb) ? mock_cce_pkg::e_cmd_writeback
                        : (state_r == e_send_wakeup) ? mock_cce_pkg::e_cmd_set_tag_wakeup
                        : mock_cce_pkg::e_cmd_set_tag;
  assign cmd_o.addr  = (state_r == e_send_wb) ? job_r.wb_addr : job_r.addr;
  assign cmd_o.way   = job_r.way;
  assign cmd_o.state = (state_r == e_send_wb) ? mock_cce_pkg::e_coh_invalid : job_r.state;

  assign data_cmd_v_o     = (state_r == e_send_data);
  assign data_cmd_o.addr  = job_r.addr;
  assign data_cmd_o.way   = job_r.way;
  assign data_cmd_o.state = job_r.state;
  assign data_cmd_o.data  = mem_rd_data_i;

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      state_r <= e_idle;
    end else begin
      case (state_r)
        e_idle: begin
          if (job_v_i) begin
            state_r <= (job_i.req_class == mock_cce_pkg::e_req_upgrade) ? e_send_wakeup
                     : (job_i.req_class == mock_cce_pkg::e_req_normal_wb) ? e_send_wb
                     : e_read_mem;
          end
        end
        e_send_wb:      if (cmd_ready_i) state_r <= e_wait_wb_data;
        e_wait_wb_data: if (data_resp_v_i) state_r <= e_read_mem;
        e_read_mem:     state_r <= e_send_data;
        e_send_data:    if (data_cmd_ready_i) state_r <= e_send_tag;
        e_send_tag:     if (cmd_ready_i) state_r <= e_wait_ack;
        e_wait_ack:     if (ack_ok) state_r <= e_idle;
        e_send_wakeup:  if (cmd_ready_i) state_r <= e_idle;
        default:        state_r <= e_idle;
      endcase
    end
  end

  always_ff @(posedge clk_i) begin
    if (job_ready_o && job_v_i) begin
      job_r <= job_i;
    end
  end

endmodule

`default_nettype wire

//--- mock_cce.sv
// top level: inbound queues, directory lookup, command issue, block memory
`timescale 1ns/1ps
`default_nettype none

module mock_cce (
  input  wire logic                          clk_i,
  input  wire logic                          reset_i,

  // inbound, ready then valid
  input  wire mock_cce_pkg::lce_req_s        lce_req_i,
  input  wire logic                          lce_req_v_i,
  output logic                               lce_req_ready_o,

  input  wire mock_cce_pkg::lce_resp_s       lce_resp_i,
  input  wire logic                          lce_resp_v_i,
  output logic                               lce_resp_ready_o,

  input  wire mock_cce_pkg::lce_data_resp_s  lce_data_resp_i,
  input  wire logic                          lce_data_resp_v_i,
  output logic                               lce_data_resp_ready_o,

  // outbound, valid held until ready
  output mock_cce_pkg::cce_cmd_s             lce_cmd_o,
  output logic                               lce_cmd_v_o,
  input  wire logic                          lce_cmd_ready_i,

  output mock_cce_pkg::cce_data_cmd_s        lce_data_cmd_o,
  output logic                               lce_data_cmd_v_o,
  input  wire logic                          lce_data_cmd_ready_i
);

  mock_cce_pkg::lce_req_s                  req_q;
  logic                                    req_q_v;
  logic                                    req_q_yumi;
  mock_cce_pkg::lce_resp_s                 resp_q;
  logic                                    resp_q_v;
  logic                                    resp_q_yumi;
  mock_cce_pkg::lce_data_resp_s            data_resp_q;
  logic                                    data_resp_q_v;
  logic                                    data_resp_q_yumi;
  mock_cce_pkg::cce_job_s                  job;
  logic                                    job_v;
  logic                                    job_ready;
  logic [mock_cce_pkg::block_addr_width_lp-1:0] mem_rd_addr;
  logic [mock_cce_pkg::block_width_lp-1:0]      mem_rd_data;
  logic                                         mem_wr_v;
  logic [mock_cce_pkg::block_addr_width_lp-1:0] mem_wr_addr;
  logic [mock_cce_pkg::block_width_lp-1:0]      mem_wr_data;

  two_entry_fifo #(.payload_t(mock_cce_pkg::lce_req_s)) u_req_fifo (
    .clk_i   (clk_i),
    .reset_i (reset_i),
    .v_i     (lce_req_v_i),
    .data_i  (lce_req_i),
    .ready_o (lce_req_ready_o),
    .v_o     (req_q_v),
    .data_o  (req_q),
    .yumi_i  (req_q_yumi)
  );

  two_entry_fifo #(.payload_t(mock_cce_pkg::lce_resp_s)) u_resp_fifo (
    .clk_i   (clk_i),
    .reset_i (reset_i),
    .v_i     (lce_resp_v_i),
    .data_i  (lce_resp_i),
    .ready_o (lce_resp_ready_o),
    .v_o     (resp_q_v),
    .data_o  (resp_q),
    .yumi_i  (resp_q_yumi)
  );

  two_entry_fifo #(.payload_t(mock_cce_pkg::lce_data_resp_s)) u_data_resp_fifo (
    .clk_i   (clk_i),
    .reset_i (reset_i),
    .v_i     (lce_data_resp_v_i),
    .data_i  (lce_data_resp_i),
    .ready_o (lce_data_resp_ready_o),
    .v_o     (data_resp_q_v),
    .data_o  (data_resp_q),
    .yumi_i  (data_resp_q_yumi)
  );

  cce_dir_lookup u_dir_lookup (
    .clk_i       (clk_i),
    .reset_i     (reset_i),
    .req_v_i     (req_q_v),
    .req_i       (req_q),
    .req_yumi_o  (req_q_yumi),
    .job_v_o     (job_v),
    .job_o       (job),
    .job_ready_i (job_ready)
  );

  cce_cmd_issue u_cmd_issue (
    .clk_i            (clk_i),
    .reset_i          (reset_i),
    .job_v_i          (job_v),
    .job_i            (job),
    .job_ready_o      (job_ready),
    .resp_v_i         (resp_q_v),
    .resp_i           (resp_q),
    .resp_yumi_o      (resp_q_yumi),
    .data_resp_v_i    (data_resp_q_v),
    .data_resp_i      (data_resp_q),
    .data_resp_yumi_o (data_resp_q_yumi),
    .cmd_v_o          (lce_cmd_v_o),
    .cmd_o            (lce_cmd_o),
    .cmd_ready_i      (lce_cmd_ready_i),
    .data_cmd_v_o     (lce_data_cmd_v_o),
    .data_cmd_o       (lce_data_cmd_o),
    .data_cmd_ready_i (lce_data_cmd_ready_i),
    .mem_rd_addr_o    (mem_rd_addr),
    .mem_rd_data_i    (mem_rd_data),
    .mem_wr_v_o       (mem_wr_v),
    .mem_wr_addr_o    (mem_wr_addr),
    .mem_wr_data_o    (mem_wr_data)
  );

  cce_block_mem u_block_mem (
    .clk_i     (clk_i),
    .reset_i   (reset_i),
    .rd_addr_i (mem_rd_addr),
    .rd_data_o (mem_rd_data),
    .wr_v_i    (mem_wr_v),
    .wr_addr_i (mem_wr_addr),
    .wr_data_i (mem_wr_data)
  );

endmodule

`default_nettype wire

//--- mock_cce_props.sv
// handshake and reset assertions bound into mock_cce
`timescale 1ns/1ps
`default_nettype none

module mock_cce_props (
  input wire logic                        clk_i,
  input wire logic                        reset_i,
  input wire logic                        lce_req_v_i,
  input wire logic                        lce_req_ready_o,
  input wire logic                        lce_resp_ready_o,
  input wire logic                        lce_data_resp_ready_o,
  input wire mock_cce_pkg::cce_cmd_s      lce_cmd_o,
  input wire logic                        lce_cmd_v_o,
  input wire logic                        lce_cmd_ready_i,
  input wire mock_cce_pkg::cce_data_cmd_s lce_data_cmd_o,
  input wire logic                        lce_data_cmd_v_o,
  input wire logic                        lce_data_cmd_ready_i
);

  int   err_cnt = 0;
  logic req_seen_r;

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      req_seen_r <= 1'b0;
    end else if (lce_req_v_i) begin
      req_seen_r <= 1'b1;
    end
  end

  // nothing leaves the CCE straight out of reset
  a_reset_quiet: assert property (@(posedge clk_i)
    reset_i |=> !lce_cmd_v_o && !lce_data_cmd_v_o)
    else begin
      err_cnt++;
      $error("outbound valid high right after reset");
    end

  a_idle: assert property (@(posedge clk_i) disable iff (reset_i)
    !req_seen_r |-> !lce_cmd_v_o && !lce_data_cmd_v_o && lce_req_ready_o
                    && lce_resp_ready_o && lce_data_resp_ready_o)
    else begin
      err_cnt++;
      $error("activity before the first request");
    end

  a_cmd_hold: assert property (@(posedge clk_i) disable iff (reset_i)
    lce_cmd_v_o && !lce_cmd_ready_i |=> lce_cmd_v_o && $stable(lce_cmd_o))
    else begin
      err_cnt++;
      $error("lce_cmd dropped or changed while stalled");
    end

  a_data_cmd_hold: assert property (@(posedge clk_i) disable iff (reset_i)
    lce_data_cmd_v_o && !lce_data_cmd_ready_i |=> lce_data_cmd_v_o && $stable(lce_data_cmd_o))
    else begin
      err_cnt++;
      $error("lce_data_cmd dropped or changed while stalled");
    end

endmodule

`default_nettype wire

//--- tb_mock_cce.sv
// testbench for mock_cce with LCE model, random requests, command and fill checks
`timescale 1ns/1ps
`default_nettype none

module tb_mock_cce;

  localparam int num_reqs_lp       = 72;
  localparam int timeout_cycles_lp = num_reqs_lp * 40 + 200;

  logic                         clk_i;
  logic                         reset_i;
  mock_cce_pkg::lce_req_s       lce_req_i;
  logic                         lce_req_v_i;
  logic                         lce_req_ready_o;
  mock_cce_pkg::lce_resp_s      lce_resp_i;
  logic                         lce_resp_v_i;
  logic                         lce_resp_ready_o;
  mock_cce_pkg::lce_data_resp_s lce_data_resp_i;
  logic                         lce_data_resp_v_i;
  logic                         lce_data_resp_ready_o;
  mock_cce_pkg::cce_cmd_s       lce_cmd_o;
  logic                         lce_cmd_v_o;
  logic                         lce_cmd_ready_i;
  mock_cce_pkg::cce_data_cmd_s  lce_data_cmd_o;
  logic                         lce_data_cmd_v_o;
  logic                         lce_data_cmd_ready_i;

  // LCE side model of tags, states and backing memory
  logic [3:0]               m_tag   [16][2];
  mock_cce_pkg::coh_state_e m_state [16][2];
  logic [31:0]              m_mem   [256];
  mock_cce_pkg::cce_job_s   exp_q [$];

  logic [31:0] stim_seed;
  logic [31:0] resp_seed;
  logic        stall_en;
  logic        wb_seen;
  logic        fill_seen;
  int          errors;
  int          cycles;

  mock_cce u_dut (.*);

  bind mock_cce mock_cce_props u_props (
    .clk_i                 (clk_i),
    .reset_i               (reset_i),
    .lce_req_v_i           (lce_req_v_i),
    .lce_req_ready_o       (lce_req_ready_o),
    .lce_resp_ready_o      (lce_resp_ready_o),
    .lce_data_resp_ready_o (lce_data_resp_ready_o),
    .lce_cmd_o             (lce_cmd_o),
    .lce_cmd_v_o           (lce_cmd_v_o),
    .lce_cmd_ready_i       (lce_cmd_ready_i),
    .lce_data_cmd_o        (lce_data_cmd_o),
    .lce_data_cmd_v_o      (lce_data_cmd_v_o),
    .lce_data_cmd_ready_i  (lce_data_cmd_ready_i)
  );

  initial begin
    clk_i = 1'b0;
    forever #20 clk_i = ~clk_i;
  end

  function automatic logic [31:0] lcg_step(input logic [31:0] s);
    return s * 32'd1664525 + 32'd1013904223;
  endfunction

  task automatic compare_hex(input string name, input logic [63:0] got, input logic [63:0] exp);
    assert (got === exp) else begin
      errors++;
      $display("Fail %s: got %0h expected %0h", name, got, exp);
    end
  endtask

  task automatic expect_true(input logic cond, input string what);
    assert (cond) else begin
      errors++;
      $display("error: %s", what);
    end
  endtask

  // pick a legal miss and record what the directory should do with it
  task automatic gen_req(output mock_cce_pkg::lce_req_s r, output mock_cce_pkg::cce_job_s e);
    logic [3:0] set;
    logic [3:0] tag;
    logic       wr;
    logic       way;
    logic       hit;
    logic       hit_way;
    logic       ok;
    ok = 1'b0;
    hit = 1'b0;
    hit_way = 1'b0;
    while (!ok) begin
      stim_seed = lcg_step(stim_seed);
      set = {2'b00, stim_seed[17:16]};
      tag = {2'b00, stim_seed[19:18]};
      wr  = stim_seed[20];
      way = stim_seed[21];
      hit = 1'b0;
      for (int w = 0; w < 2; w++) begin
        if (m_state[set][w] != mock_cce_pkg::e_coh_invalid && m_tag[set][w] == tag) begin
          hit = 1'b1;
          hit_way = w[0];
        end
      end
      // a block held modified never misses
      ok = !hit || (m_state[set][hit_way] == mock_cce_pkg::e_coh_shared);
    end
    if (hit) wr = 1'b1;
    r.addr      = {tag, set};
    r.wr        = wr;
    r.lru_way   = way;
    r.lru_dirty = (m_state[set][way] == mock_cce_pkg::e_coh_modified);
    e.req_class = hit ? mock_cce_pkg::e_req_upgrade
                : r.lru_dirty ? mock_cce_pkg::e_req_normal_wb : mock_cce_pkg::e_req_normal;
    e.addr      = r.addr;
    e.way       = hit ? hit_way : way;
    e.state     = wr ? mock_cce_pkg::e_coh_modified : mock_cce_pkg::e_coh_shared;
    e.wb_addr   = {m_tag[set][way], set};
    m_tag[set][e.way]   = tag;
    m_state[set][e.way] = e.state;
  endtask

  task automatic send_reqs(input int n, input logic back_to_back);
    mock_cce_pkg::lce_req_s r;
    mock_cce_pkg::cce_job_s e;
    for (int i = 0; i < n; i++) begin
      gen_req(r, e);
      exp_q.push_back(e);
      lce_req_i   <= r;
      lce_req_v_i <= 1'b1;
      @(posedge clk_i);
      while (!lce_req_ready_o) @(posedge clk_i);
      if (!back_to_back) begin
        lce_req_v_i <= 1'b0;
        while (exp_q.size() != 0) @(posedge clk_i);
      end
    end
    lce_req_v_i <= 1'b0;
  endtask

  task automatic verify_fill();
    mock_cce_pkg::cce_job_s e;
    expect_true(exp_q.size() != 0, "fill with no request pending");
    if (exp_q.size() != 0) begin
      e = exp_q[0];
      expect_true(e.req_class != mock_cce_pkg::e_req_upgrade && !fill_seen
                  && (e.req_class != mock_cce_pkg::e_req_normal_wb || wb_seen),
                  "fill out of order");
      compare_hex("lce_data_cmd_o.addr", 64'(lce_data_cmd_o.addr), 64'(e.addr));
      compare_hex("lce_data_cmd_o.way", 64'(lce_data_cmd_o.way), 64'(e.way));
      compare_hex("lce_data_cmd_o.state", 64'(lce_data_cmd_o.state), 64'(e.state));
      compare_hex("lce_data_cmd_o.data", 64'(lce_data_cmd_o.data), 64'(m_mem[e.addr]));
      fill_seen = 1'b1;
    end
  endtask

  task automatic answer_cmd();
    mock_cce_pkg::cce_job_s e;
    logic [31:0]            wb_data;
    expect_true(exp_q.size() != 0, "command with no request pending");
    if (exp_q.size() != 0) begin
      e = exp_q[0];
      if (e.req_class == mock_cce_pkg::e_req_upgrade) begin
        compare_hex("lce_cmd_o.cmd_type", 64'(lce_cmd_o.cmd_type),
                    64'(mock_cce_pkg::e_cmd_set_tag_wakeup));
        compare_hex("lce_cmd_o.addr", 64'(lce_cmd_o.addr), 64'(e.addr));
        compare_hex("lce_cmd_o.way", 64'(lce_cmd_o.way), 64'(e.way));
        compare_hex("lce_cmd_o.state", 64'(lce_cmd_o.state), 64'(e.state));
        void'(exp_q.pop_front());
      end else if (e.req_class == mock_cce_pkg::e_req_normal_wb && !wb_seen) begin
        compare_hex("lce_cmd_o.cmd_type", 64'(lce_cmd_o.cmd_type),
                    64'(mock_cce_pkg::e_cmd_writeback));
        compare_hex("lce_cmd_o.addr", 64'(lce_cmd_o.addr), 64'(e.wb_addr));
        compare_hex("lce_cmd_o.way", 64'(lce_cmd_o.way), 64'(e.way));
        resp_seed = lcg_step(resp_seed);
        wb_data = resp_seed;
        m_mem[e.wb_addr]  = wb_data;
        lce_data_resp_i   <= '{addr: e.wb_addr, data: wb_data};
        lce_data_resp_v_i <= 1'b1;
        wb_seen = 1'b1;
      end else begin
        expect_true(fill_seen, "set_tag sent before the fill");
        compare_hex("lce_cmd_o.cmd_type", 64'(lce_cmd_o.cmd_type),
                    64'(mock_cce_pkg::e_cmd_set_tag));
        compare_hex("lce_cmd_o.addr", 64'(lce_cmd_o.addr), 64'(e.addr));
        compare_hex("lce_cmd_o.way", 64'(lce_cmd_o.way), 64'(e.way));
        compare_hex("lce_cmd_o.state", 64'(lce_cmd_o.state), 64'(e.state));
        lce_resp_i   <= '{addr: e.addr};
        lce_resp_v_i <= 1'b1;
        void'(exp_q.pop_front());
        wb_seen   = 1'b0;
        fill_seen = 1'b0;
      end
    end
  endtask

  // LCE side responder that samples transfers and randomizes outbound ready
  always @(posedge clk_i) begin
    if (!reset_i) begin
      if (lce_resp_v_i && lce_resp_ready_o) lce_resp_v_i <= 1'b0;
      if (lce_data_resp_v_i && lce_data_resp_ready_o) lce_data_resp_v_i <= 1'b0;
      if (lce_data_cmd_v_o && lce_data_cmd_ready_i) verify_fill();
      if (lce_cmd_v_o && lce_cmd_ready_i) answer_cmd();
      resp_seed = lcg_step(resp_seed);
      lce_cmd_ready_i      <= !stall_en || (resp_seed[27:26] != 2'b00);
      lce_data_cmd_ready_i <= !stall_en || (resp_seed[29:28] != 2'b00);
    end
  end

  always @(posedge clk_i) begin
    cycles++;
    if (cycles > timeout_cycles_lp) begin
      $display("timeout: the DUT stopped answering after %0d cycles", cycles);
      $display("Some tests failed");
      $finish;
    end
  end

  initial begin
    errors = 0;
    cycles = 0;
    stim_seed = 32'h11e2d2ec;
    resp_seed = 32'h11e2d2ec ^ 32'h5a5a5a5a;
    stall_en  = 1'b0;
    wb_seen   = 1'b0;
    fill_seen = 1'b0;
    for (int s = 0; s < 16; s++) begin
      for (int w = 0; w < 2; w++) begin
        m_tag[s][w]   = 4'h0;
        m_state[s][w] = mock_cce_pkg::e_coh_invalid;
      end
    end
    for (int a = 0; a < 256; a++) m_mem[a] = 32'h0;
    reset_i = 1'b1;
    lce_req_i = '0;
    lce_req_v_i = 1'b0;
    lce_resp_i = '0;
    lce_resp_v_i = 1'b0;
    lce_data_resp_i = '0;
    lce_data_resp_v_i = 1'b0;
    lce_cmd_ready_i = 1'b1;
    lce_data_cmd_ready_i = 1'b1;
    repeat (4) @(posedge clk_i);
    reset_i <= 1'b0;
    // quiet period before the first request
    repeat (6) @(posedge clk_i);
    send_reqs(30, 1'b0);
    stall_en = 1'b1;
    send_reqs(30, 1'b0);
    send_reqs(12, 1'b1);
    while (exp_q.size() != 0) @(posedge clk_i);
    repeat (5) @(posedge clk_i);
    $display("errors: %0d check, %0d assertion", errors, u_dut.u_props.err_cnt);
    if (errors == 0 && u_dut.u_props.err_cnt == 0) begin
      $display("All tests passed");
    end else begin
      $display("Some tests failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- filelist.f
mock_cce_pkg.sv
two_entry_fifo.sv
cce_dir_lookup.sv
cce_block_mem.sv
cce_cmd_issue.sv
mock_cce.sv
mock_cce_props.sv
tb_mock_cce.sv

//--- run.sh
#!/bin/bash
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert -Wno-fatal -f filelist.f --top-module tb_mock_cce \
  -o sim_mock_cce > build.log 2>&1 || { cat build.log; echo "build failed"; exit 1; }
./obj_dir/sim_mock_cce +verilator+error+limit+1000 > sim.log 2>&1 ; cat sim.log
grep -q "Some tests failed" sim.log && { echo "simulation reported failure"; exit 1; }
grep -q "All tests passed" sim.log || { echo "simulation ended without a result"; exit 1; }
exit 0
